// File: src/boot_settings.svh
`ifndef BOOT_SETTINGS_SVH
`define BOOT_SETTINGS_SVH

// Flash byte address of the first image byte
`define BOOT_FLASH_BASE 24'h010000

// Image size in 32-bit words
`define BOOT_WORDS 16

// Boot RAM word address width, must cover BOOT_WORDS
`define BOOT_RAM_AW 4

// Plain serial read opcode of the flash
`define BOOT_READ_CMD 8'h03

// Clocks per UART bit
// small value keeps simulation short
`define BOOT_UART_DIV 8

`endif

// File: src/boot_pkg.sv
`default_nettype none

`include "boot_settings.svh"

package boot_pkg;

   // Image word, also the checksum width
   typedef logic [31:0] word_t;

   // Word address into the boot RAM
   typedef logic [`BOOT_RAM_AW-1:0] ram_addr_t;

   // SPI reader phases
   typedef enum logic [2:0] {
      SPI_IDLE,
      SPI_CMD,    // 8 opcode bits
      SPI_ADDR,   // 24 address bits
      SPI_DATA,   // read_len bytes in
      SPI_FINISH  // CS released, report end
   } spi_phase_t;

   // Boot sequencer states
   typedef enum logic [1:0] {
      SEQ_IDLE,
      SEQ_LOAD,   // Flash to RAM copy
      SEQ_REPORT, // Checksum out on UART
      SEQ_DONE
   } seq_state_t;

endpackage

`default_nettype wire

// File: src/spi_flash_reader.sv
`default_nettype none

`include "boot_settings.svh"

module spi_flash_reader import boot_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        read_start,
   input  logic [15:0] read_len,
   output logic        byte_valid,
   output logic [7:0]  byte_data,
   output logic        read_end,
   output logic        spi_sck,
   output logic        spi_cs_n,
   output logic        spi_mosi,
   input  logic        spi_miso
);

   spi_phase_t  phase;
   logic [31:0] tx_shift;  // Opcode then address MSB first
   logic [2:0]  bit_cnt;   // Bit within current byte
   logic [15:0] byte_cnt;  // Byte within current phase
   logic [15:0] len_q;     // Latched data length
   logic [6:0]  rx_shift;  // First seven bits of incoming byte
   logic        last_byte;

   // Top bit goes out with zeros behind the address
   assign spi_mosi = tx_shift[31];

   // End of phase test for the eighth falling edge
   always_comb begin
      case (phase)
         SPI_CMD:  last_byte = 1'b1;
         SPI_ADDR: last_byte = (byte_cnt == 16'd2);
         default:  last_byte = (byte_cnt == len_q - 16'd1);
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         phase      <= SPI_IDLE;
         spi_cs_n   <= 1'b1;
         spi_sck    <= 1'b0;
         tx_shift   <= '0;
         bit_cnt    <= '0;
         byte_cnt   <= '0;
         byte_valid <= 1'b0;
         read_end   <= 1'b0;
      end else begin
         byte_valid <= 1'b0; // Strobes default low
         read_end   <= 1'b0;
         case (phase)
            SPI_IDLE: begin
               if (read_start) begin
                  spi_cs_n <= 1'b0; // Select one cycle after start
                  tx_shift <= {`BOOT_READ_CMD, `BOOT_FLASH_BASE};
                  bit_cnt  <= '0;
                  byte_cnt <= '0;
                  phase    <= SPI_CMD;
               end
            end
            SPI_FINISH: begin
               read_end <= 1'b1; // CS already high here
               phase    <= SPI_IDLE;
            end
            default: begin
               spi_sck <= ~spi_sck; // Half bit per clk
               if (!spi_sck) begin
                  // Rising SCK ends a data byte after bit 7
                  byte_valid <= (phase == SPI_DATA) && (bit_cnt == 3'd7);
               end else begin
                  // Falling SCK shifts the next MOSI bit out
                  tx_shift <= {tx_shift[30:0], 1'b0};
                  bit_cnt  <= bit_cnt + 3'd1;
                  if (bit_cnt == 3'd7) begin
                     byte_cnt <= byte_cnt + 16'd1;
                     if (last_byte) begin
                        byte_cnt <= '0;
                        if (phase == SPI_CMD) begin
                           phase <= SPI_ADDR;
                        end else if (phase == SPI_ADDR) begin
                           phase <= SPI_DATA;
                        end else begin
                           phase    <= SPI_FINISH;
                           spi_cs_n <= 1'b1; // Deselect with SCK back low
                        end
                     end
                  end
               end
            end
         endcase
      end
   end

   // Length latch and receive shifter
   always_ff @(posedge clk) begin
      if (phase == SPI_IDLE && read_start) begin
         len_q <= read_len;
      end
      if (phase == SPI_DATA && !spi_sck) begin
         rx_shift <= {rx_shift[5:0], spi_miso}; // MSB arrives first
         if (bit_cnt == 3'd7) begin
            byte_data <= {rx_shift, spi_miso};
         end
      end
   end

endmodule

`default_nettype wire

// File: src/boot_sequencer.sv
`default_nettype none

`include "boot_settings.svh"

module boot_sequencer import boot_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        boot_start,
   output logic        read_start,
   output logic [15:0] read_len,
   input  logic        byte_valid,
   input  logic [7:0]  byte_data,
   input  logic        read_end,
   output logic        wr_en,
   output ram_addr_t   wr_addr,
   output word_t       wr_data,
   output logic        tx_start,
   output logic [7:0]  tx_byte,
   input  logic        tx_busy,
   output logic        busy,
   output logic        boot_done
);

   seq_state_t state;
   logic [1:0] lane;     // Byte lane of next byte
   logic [2:0] tx_cnt;   // Checksum bytes already sent
   word_t      checksum;
   word_t      word_next;
   logic       tx_slot;  // UART free and no pulse in flight

   assign read_len  = 16'(`BOOT_WORDS * 4);
   assign word_next = {byte_data, wr_data[31:8]}; // Little-endian fill from top
   assign busy      = (state == SEQ_LOAD) || (state == SEQ_REPORT);
   assign boot_done = (state == SEQ_DONE);
   // tx_busy lags tx_start by one cycle
   assign tx_slot   = !tx_busy && !tx_start;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= SEQ_IDLE;
         read_start <= 1'b0;
         wr_en      <= 1'b0;
         wr_addr    <= '0;
         tx_start   <= 1'b0;
         lane       <= '0;
         tx_cnt     <= '0;
         checksum   <= '0;
      end else begin
         read_start <= 1'b0;
         wr_en      <= 1'b0;
         tx_start   <= 1'b0;
         if (wr_en) begin
            wr_addr <= wr_addr + 1'b1; // Step after each write
         end
         case (state)
            SEQ_IDLE, SEQ_DONE: begin
               if (boot_start) begin
                  read_start <= 1'b1;
                  wr_addr    <= '0;
                  lane       <= '0;
                  checksum   <= '0;
                  state      <= SEQ_LOAD;
               end
            end
            SEQ_LOAD: begin
               if (byte_valid) begin
                  lane <= lane + 2'd1;
                  if (lane == 2'd3) begin
                     wr_en    <= 1'b1;
                     checksum <= checksum + word_next;
                  end
               end
               if (read_end) begin
                  tx_cnt <= '0;
                  state  <= SEQ_REPORT;
               end
            end
            SEQ_REPORT: begin
               if (tx_slot) begin
                  if (tx_cnt == 3'd4) begin
                     state <= SEQ_DONE; // Last stop bit finished
                  end else begin
                     tx_start <= 1'b1;
                     tx_cnt   <= tx_cnt + 3'd1;
                  end
               end
            end
            default: state <= SEQ_IDLE;
         endcase
      end
   end

   // Word assembler and UART byte select
   always_ff @(posedge clk) begin
      if (state == SEQ_LOAD && byte_valid) begin
         wr_data <= word_next;
      end
      if (state == SEQ_REPORT && tx_slot) begin
         tx_byte <= checksum[{tx_cnt[1:0], 3'b000} +: 8]; // Lowest byte first
      end
   end

endmodule

`default_nettype wire

// File: src/boot_ram.sv
`default_nettype none

`include "boot_settings.svh"

module boot_ram import boot_pkg::*; (
   input  logic      clk,
   input  logic      wr_en,
   input  ram_addr_t wr_addr,
   input  word_t     wr_data,
   input  ram_addr_t rd_addr,
   output word_t     rd_data
);

   localparam int DEPTH = 2 ** `BOOT_RAM_AW;

   word_t mem [DEPTH]; // Loaded image

   // Write port
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // Read data one cycle after address
   always_ff @(posedge clk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

`default_nettype wire

// File: src/uart_tx.sv
`default_nettype none

`include "boot_settings.svh"

module uart_tx (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       tx_start,
   input  logic [7:0] tx_byte,
   output logic       tx_busy,
   output logic       uart_txd
);

   localparam int BAUD_W = (`BOOT_UART_DIV > 1) ? $clog2(`BOOT_UART_DIV) : 1;

   logic [BAUD_W-1:0] baud_cnt;
   logic [3:0]        bit_cnt;   // Bits done after start bit
   logic [8:0]        shreg;     // Data LSB first, then stop
   logic              bit_end;

   assign bit_end = (baud_cnt == BAUD_W'(`BOOT_UART_DIV - 1));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tx_busy  <= 1'b0;
         uart_txd <= 1'b1; // Line idles high
         baud_cnt <= '0;
         bit_cnt  <= '0;
      end else if (!tx_busy) begin
         if (tx_start) begin
            tx_busy  <= 1'b1;
            uart_txd <= 1'b0; // Start bit
            baud_cnt <= '0;
            bit_cnt  <= '0;
         end
      end else if (bit_end) begin
         baud_cnt <= '0;
         if (bit_cnt == 4'd9) begin
            tx_busy <= 1'b0; // Stop bit over
         end else begin
            uart_txd <= shreg[0];
            bit_cnt  <= bit_cnt + 4'd1;
         end
      end else begin
         baud_cnt <= baud_cnt + 1'b1;
      end
   end

   // Frame shifter
   always_ff @(posedge clk) begin
      if (!tx_busy && tx_start) begin
         shreg <= {1'b1, tx_byte};
      end else if (tx_busy && bit_end) begin
         shreg <= {1'b1, shreg[8:1]};
      end
   end

endmodule

`default_nettype wire

// File: src/flash_boot_top.sv
`default_nettype none

module flash_boot_top import boot_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      boot_start,
   input  ram_addr_t rd_addr,     // Debug read port
   output word_t     rd_data,
   output logic      spi_sck,
   output logic      spi_cs_n,
   output logic      spi_mosi,
   input  logic      spi_miso,
   output logic      uart_txd,
   output logic      busy,
   output logic      boot_done
);

   logic        read_start;
   logic [15:0] read_len;
   logic        byte_valid;
   logic [7:0]  byte_data;
   logic        read_end;
   logic        wr_en;
   ram_addr_t   wr_addr;
   word_t       wr_data;
   logic        tx_start;
   logic [7:0]  tx_byte;
   logic        tx_busy;

   // Flash side
   spi_flash_reader u_reader (
      .clk        (clk),
      .rst_n      (rst_n),
      .read_start (read_start),
      .read_len   (read_len),
      .byte_valid (byte_valid),
      .byte_data  (byte_data),
      .read_end   (read_end),
      .spi_sck    (spi_sck),
      .spi_cs_n   (spi_cs_n),
      .spi_mosi   (spi_mosi),
      .spi_miso   (spi_miso)
   );

   boot_sequencer u_seq (
      .clk        (clk),
      .rst_n      (rst_n),
      .boot_start (boot_start),
      .read_start (read_start),
      .read_len   (read_len),
      .byte_valid (byte_valid),
      .byte_data  (byte_data),
      .read_end   (read_end),
      .wr_en      (wr_en),
      .wr_addr    (wr_addr),
      .wr_data    (wr_data),
      .tx_start   (tx_start),
      .tx_byte    (tx_byte),
      .tx_busy    (tx_busy),
      .busy       (busy),
      .boot_done  (boot_done)
   );

   boot_ram u_ram (
      .clk     (clk),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   // Debug serial out
   uart_tx u_uart (
      .clk      (clk),
      .rst_n    (rst_n),
      .tx_start (tx_start),
      .tx_byte  (tx_byte),
      .tx_busy  (tx_busy),
      .uart_txd (uart_txd)
   );

endmodule

`default_nettype wire

// File: testbench/spi_flash_model.sv
`default_nettype none

`include "boot_settings.svh"

module spi_flash_model (
   input  logic sck,
   input  logic cs_n,
   input  logic mosi,
   output logic miso
);
   timeunit 1ns;
   timeprecision 1ps;

   logic [7:0]  opcode    = 8'h00;  // Last received command
   logic [23:0] addr      = 24'h0;  // Last received start address
   int          cmd_count = 0;      // Completed command headers
   logic [31:0] cmd_shift = '0;     // Opcode and address, MSB first
   int          bit_cnt   = 0;      // Rising edges since select
   logic        out_bit   = 1'b0;
   int          idx;
   logic [7:0]  cur_byte;

   // Fill rule of the board image
   function automatic logic [7:0] pattern_byte(input logic [23:0] a);
      return (a[7:0] ^ 8'h5a) + a[15:8];
   endfunction

   assign miso = cs_n ? 1'b0 : out_bit; // Quiet while deselected

   // Header bits in on rising SCK, counter cleared by deselect
   always @(posedge sck or posedge cs_n) begin
      if (cs_n) begin
         bit_cnt <= 0;
      end else begin
         cmd_shift <= {cmd_shift[30:0], mosi};
         bit_cnt   <= bit_cnt + 1;
         if (bit_cnt == 31) begin
            opcode    <= cmd_shift[30:23];
            addr      <= {cmd_shift[22:0], mosi}; // Last address bit still on MOSI
            cmd_count <= cmd_count + 1;
         end
      end
   end

   // Data out on falling SCK so it is stable at the next rising edge
   always @(negedge sck) begin
      if (!cs_n && bit_cnt >= 32) begin
         idx      = bit_cnt - 32;
         cur_byte = pattern_byte(addr + 24'(idx / 8)); // Address auto-increments
         out_bit  <= cur_byte[7 - (idx % 8)];
      end
   end

endmodule

`default_nettype wire

// File: testbench/tb_toplevel.sv
`default_nettype none

`include "boot_settings.svh"

module tb_toplevel import boot_pkg::*; ();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int WAIT_LIMIT = 4000; // Cycles allowed per wait loop

   logic      clk = 1'b0;
   logic      rst_n;
   logic      boot_start;
   ram_addr_t rd_addr;
   word_t     rd_data;
   logic      spi_sck;
   logic      spi_cs_n;
   logic      spi_mosi;
   logic      spi_miso;
   logic      uart_txd;
   logic      busy;
   logic      boot_done;

   int errors = 0;
   int checks = 0;

   flash_boot_top UUT (.*);

   // Flash part on the SPI pins
   spi_flash_model flash (
      .sck  (spi_sck),
      .cs_n (spi_cs_n),
      .mosi (spi_mosi),
      .miso (spi_miso)
   );

   always #20 clk = ~clk; // 40 ns period

   // Image byte at offset from the flash base
   function automatic logic [7:0] expected_byte(input int offset);
      logic [23:0] a;
      a = 24'(`BOOT_FLASH_BASE + offset);
      return (a[7:0] ^ 8'h5a) + a[15:8];
   endfunction

   // Little-endian word i of the image
   function automatic word_t expected_word(input int i);
      return {expected_byte(4 * i + 3), expected_byte(4 * i + 2),
              expected_byte(4 * i + 1), expected_byte(4 * i)};
   endfunction

   function automatic word_t expected_sum();
      word_t s;
      s = '0;
      for (int i = 0; i < `BOOT_WORDS; i++) begin
         s += expected_word(i); // Wraps at 32 bits
      end
      return s;
   endfunction

   task automatic timeout_abort(input string what);
      errors++;
      $display("Timeout while waiting for %s", what);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("TEST FAIL");
      $finish;
   endtask

   task automatic check_reset_state();
      @(negedge clk);
      checks++;
      // Pins and status packed MSB first
      if ({spi_cs_n, spi_sck, uart_txd, busy, boot_done} !== 5'b10100) begin
         errors++;
         $display("FAILED {spi_cs_n,spi_sck,uart_txd,busy,boot_done}: expected %h, got %h",
                  5'b10100, {spi_cs_n, spi_sck, uart_txd, busy, boot_done});
      end
   endtask

   // One 8N1 frame sampled near each bit centre
   task automatic receive_frame(output logic [7:0] data);
      int cnt;
      cnt = 0;
      while (uart_txd !== 1'b0) begin
         @(negedge clk);
         cnt++;
         if (cnt > WAIT_LIMIT) timeout_abort("a UART start bit");
      end
      repeat (`BOOT_UART_DIV / 2) @(negedge clk); // Middle of start bit
      checks++;
      if (uart_txd !== 1'b0) begin
         errors++;
         $display("FAILED uart_txd start bit: expected %h, got %h", 1'b0, uart_txd);
      end
      for (int b = 0; b < 8; b++) begin
         repeat (`BOOT_UART_DIV) @(negedge clk);
         data[b] = uart_txd; // LSB first
      end
      repeat (`BOOT_UART_DIV) @(negedge clk);
      checks += 2;
      if (uart_txd !== 1'b1) begin
         errors++;
         $display("FAILED uart_txd stop bit: expected %h, got %h", 1'b1, uart_txd);
      end
      if (boot_done !== 1'b0) begin
         errors++;
         $display("FAILED boot_done: expected %h, got %h", 1'b0, boot_done);
      end
   endtask

   // Full boot with checksum decode and an optional extra start while busy
   task automatic run_boot(input bit poke_busy, input int cmds);
      logic [7:0] rx;
      word_t      got_sum;
      int         cnt;
      @(posedge clk);
      boot_start <= 1'b1;
      @(posedge clk);
      boot_start <= 1'b0;
      @(negedge clk);
      checks += 2;
      if (busy !== 1'b1) begin
         errors++;
         $display("FAILED busy: expected %h, got %h", 1'b1, busy);
      end
      if (boot_done !== 1'b0) begin
         errors++;
         $display("FAILED boot_done: expected %h, got %h", 1'b0, boot_done);
      end
      if (poke_busy) begin
         repeat (400) @(posedge clk); // Mid data phase with words already in RAM
         boot_start <= 1'b1;
         @(posedge clk);
         boot_start <= 1'b0;
      end
      for (int f = 0; f < 4; f++) begin
         receive_frame(rx);
         got_sum[8 * f +: 8] = rx;
      end
      cnt = 0;
      while (boot_done !== 1'b1) begin
         @(negedge clk);
         cnt++;
         if (cnt > WAIT_LIMIT) timeout_abort("boot_done");
      end
      checks += 6;
      if (got_sum !== expected_sum()) begin
         errors++;
         $display("FAILED checksum: expected %h, got %h", expected_sum(), got_sum);
      end
      if (busy !== 1'b0) begin
         errors++;
         $display("FAILED busy: expected %h, got %h", 1'b0, busy);
      end
      if (spi_cs_n !== 1'b1) begin
         errors++;
         $display("FAILED spi_cs_n: expected %h, got %h", 1'b1, spi_cs_n);
      end
      if (flash.opcode !== `BOOT_READ_CMD) begin
         errors++;
         $display("FAILED flash opcode: expected %h, got %h", `BOOT_READ_CMD, flash.opcode);
      end
      if (flash.addr !== `BOOT_FLASH_BASE) begin
         errors++;
         $display("FAILED flash addr: expected %h, got %h", `BOOT_FLASH_BASE, flash.addr);
      end
      if (flash.cmd_count !== cmds) begin
         errors++;
         $display("FAILED flash cmd_count: expected %h, got %h", cmds, flash.cmd_count);
      end
   endtask

   // Debug port reads in shuffled order
   task automatic check_ram();
      int order [`BOOT_WORDS];
      int j;
      int tmp;
      for (int i = 0; i < `BOOT_WORDS; i++) begin
         order[i] = i;
      end
      for (int i = `BOOT_WORDS - 1; i > 0; i--) begin
         j        = int'($urandom % (i + 1));
         tmp      = order[i];
         order[i] = order[j];
         order[j] = tmp;
      end
      for (int i = 0; i < `BOOT_WORDS; i++) begin
         @(posedge clk);
         rd_addr <= ram_addr_t'(order[i]);
         @(posedge clk); // Registered read
         @(negedge clk);
         checks++;
         if (rd_data !== expected_word(order[i])) begin
            errors++;
            $display("FAILED rd_data[%0d]: expected %h, got %h",
                     order[i], expected_word(order[i]), rd_data);
         end
      end
   endtask

   initial begin
      int gap;
      void'($urandom(32'h72be));
      rst_n      = 1'b0;
      boot_start = 1'b0;
      rd_addr    = '0;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      check_reset_state();
      run_boot(1'b1, 1); // Second start lands while busy
      check_ram();
      gap = 1 + int'($urandom % 64);
      repeat (gap) @(posedge clk);
      run_boot(1'b0, 2);
      check_ram();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: flash_boot.f
+incdir+src
src/boot_pkg.sv
src/spi_flash_reader.sv
src/boot_sequencer.sv
src/boot_ram.sv
src/uart_tx.sv
src/flash_boot_top.sv
testbench/spi_flash_model.sv
testbench/tb_toplevel.sv

// File: run_sim.sh
#!/bin/sh
# Build tb_toplevel with Verilator, run it and search the log for the pass line
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_toplevel -f flash_boot.f -o sim_boot \
   && ./obj_dir/sim_boot | tee sim.log \
   && grep -q "TEST PASS" sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
